/* include/usb_trigger_params.svh */
`ifndef USB_TRIGGER_PARAMS_SVH
`define USB_TRIGGER_PARAMS_SVH

//////////////////////////////
// pattern matcher sizes
//////////////////////////////
`define PATTERN_BYTES      8
`define PATTERN_CNT_WIDTH  4    // holds 1..8

//////////////////////////////
// trigger pulse train
//////////////////////////////
`define NUM_PULSES         4
`define PULSE_IDX_WIDTH    2
`define TRIG_DELAY_WIDTH   20   // cycles of fe_clk
`define TRIG_WIDTH_WIDTH   17

// register bus
`define BYTECNT_WIDTH      4

// register map
`define REG_ARM            8'h00
`define REG_SPEED          8'h01
`define REG_PATTERN        8'h02
`define REG_MASK           8'h03
`define REG_PATTERN_BYTES  8'h04
`define REG_NUM_TRIGGERS   8'h05
`define REG_TRIG_DELAY     8'h06   // 3 byte lanes per pulse
`define REG_TRIG_WIDTH     8'h07   // 3 byte lanes per pulse
`define REG_STATUS         8'h08

`endif

/* hw/usb_trigger_pkg.sv */
`include "usb_trigger_params.svh"

package usb_trigger_pkg;

   //////////////////////////////
   // register bus types
   //////////////////////////////
   typedef logic [7:0]                      reg_addr_t;
   typedef logic [7:0]                      reg_data_t;
   typedef logic [`BYTECNT_WIDTH-1:0]       bytecnt_t;

   // data byte from the PHY
   typedef logic [7:0]                      fe_byte_t;

   // byte k of a pattern or mask sits at bits 8k+7:8k
   typedef logic [`PATTERN_BYTES*8-1:0]     pattern_t;
   typedef logic [`PATTERN_CNT_WIDTH-1:0]   pattern_cnt_t;

   typedef logic [`PULSE_IDX_WIDTH-1:0]     pulse_idx_t;    // pulse count minus one
   typedef logic [`TRIG_DELAY_WIDTH-1:0]    trig_delay_t;
   typedef logic [`TRIG_WIDTH_WIDTH-1:0]    trig_width_t;

   typedef enum logic [1:0] {
      SPEED_FS   = 2'd0,
      SPEED_LS   = 2'd1,
      SPEED_HS   = 2'd2,
      SPEED_AUTO = 2'd3   // no autodetect, behaves as FS
   } usb_speed_t;

   typedef enum logic [1:0] {
      TRIG_IDLE,
      TRIG_DELAY,
      TRIG_PULSE
   } trig_state_t;

endpackage

/* hw/usb_trigger_regs.sv */
`timescale 1ns/100ps
`include "usb_trigger_params.svh"

module usb_trigger_regs import usb_trigger_pkg::*; (
   input  logic          fe_clk,
   input  logic          rst_i,
   input  reg_addr_t     reg_addr_i,
   input  bytecnt_t      reg_bytecnt_i,
   input  reg_data_t     reg_wdata_i,
   input  logic          reg_write_i,
   output reg_data_t     reg_rdata_o,
   input  logic          trig_done_i,
   output logic          armed_o,
   output usb_speed_t    speed_o,
   output pattern_t      pattern_o,
   output pattern_t      mask_o,
   output pattern_cnt_t  pattern_bytes_o,
   output pulse_idx_t    num_triggers_o,
   output trig_delay_t   trig_delay_o [`NUM_PULSES],
   output trig_width_t   trig_width_o [`NUM_PULSES]
);

   localparam int PAT_IDX_W = $clog2(`PATTERN_BYTES);
   localparam int LANE_BITS = 24;   // three byte lanes per pulse

   logic          armed_q;
   logic          triggered_q;
   usb_speed_t    speed_q;
   pattern_t      pattern_q;
   pattern_t      mask_q;
   pattern_cnt_t  pattern_bytes_q;
   pulse_idx_t    num_triggers_q;
   trig_delay_t   trig_delay_q [`NUM_PULSES];
   trig_width_t   trig_width_q [`NUM_PULSES];

   logic                  pat_lane_ok;
   logic                  lane_hit;
   pulse_idx_t            lane_pulse;
   logic [1:0]            lane_byte;
   logic [LANE_BITS-1:0]  delay_bytes;
   logic [LANE_BITS-1:0]  width_bytes;
   logic [LANE_BITS-1:0]  delay_wr;
   logic [LANE_BITS-1:0]  width_wr;
   pattern_cnt_t          pattern_bytes_wr;

   //////////////////////////////
   // byte lane decode
   //////////////////////////////
   assign pat_lane_ok = reg_bytecnt_i < bytecnt_t'(`PATTERN_BYTES);

   // bytecnt 3p+b -> pulse p, byte b
   always_comb begin
      lane_hit   = 1'b0;
      lane_pulse = '0;
      lane_byte  = '0;
      for (int p = 0; p < `NUM_PULSES; p++) begin
         for (int b = 0; b < 3; b++) begin
            if (reg_bytecnt_i == bytecnt_t'(3 * p + b)) begin
               lane_hit   = 1'b1;
               lane_pulse = pulse_idx_t'(p);
               lane_byte  = 2'(b);
            end
         end
      end
   end

   assign delay_bytes = LANE_BITS'(trig_delay_q[lane_pulse]);  // upper bits read as zero
   assign width_bytes = LANE_BITS'(trig_width_q[lane_pulse]);

   always_comb begin
      delay_wr = delay_bytes;
      width_wr = width_bytes;
      delay_wr[8*lane_byte +: 8] = reg_wdata_i;
      width_wr[8*lane_byte +: 8] = reg_wdata_i;
   end

   // clip length into 1..8
   always_comb begin
      if (reg_wdata_i == 8'd0)
         pattern_bytes_wr = pattern_cnt_t'(1);
      else if (reg_wdata_i > 8'(`PATTERN_BYTES))
         pattern_bytes_wr = pattern_cnt_t'(`PATTERN_BYTES);
      else
         pattern_bytes_wr = reg_wdata_i[`PATTERN_CNT_WIDTH-1:0];
   end

   //////////////////////////////
   // register writes
   //////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         armed_q         <= 1'b0;
         triggered_q     <= 1'b0;
         speed_q         <= SPEED_FS;
         pattern_q       <= '0;
         mask_q          <= '0;
         pattern_bytes_q <= pattern_cnt_t'(1);
         num_triggers_q  <= '0;
         for (int p = 0; p < `NUM_PULSES; p++) begin
            trig_delay_q[p] <= '0;
            trig_width_q[p] <= trig_width_t'(1);
         end
      end else begin
         if (reg_write_i && reg_addr_i == `REG_ARM) begin
            armed_q     <= reg_wdata_i[0];
            triggered_q <= 1'b0;   // new run
         end else if (trig_done_i) begin
            armed_q     <= 1'b0;   // train finished, disarm
            triggered_q <= 1'b1;
         end
         if (reg_write_i) begin
            case (reg_addr_i)
               `REG_SPEED:         speed_q <= usb_speed_t'(reg_wdata_i[1:0]);
               `REG_PATTERN:       if (pat_lane_ok)
                  pattern_q[8*reg_bytecnt_i[PAT_IDX_W-1:0] +: 8] <= reg_wdata_i;
               `REG_MASK:          if (pat_lane_ok)
                  mask_q[8*reg_bytecnt_i[PAT_IDX_W-1:0] +: 8] <= reg_wdata_i;
               `REG_PATTERN_BYTES: pattern_bytes_q <= pattern_bytes_wr;
               `REG_NUM_TRIGGERS:  num_triggers_q  <= reg_wdata_i[`PULSE_IDX_WIDTH-1:0];
               `REG_TRIG_DELAY:    if (lane_hit)
                  trig_delay_q[lane_pulse] <= delay_wr[`TRIG_DELAY_WIDTH-1:0];
               `REG_TRIG_WIDTH:    if (lane_hit)
                  trig_width_q[lane_pulse] <= width_wr[`TRIG_WIDTH_WIDTH-1:0];
               default: ;
            endcase
         end
      end
   end

   //////////////////////////////
   // read mux, no side effects
   //////////////////////////////
   always_comb begin
      reg_rdata_o = '0;
      case (reg_addr_i)
         `REG_ARM:           reg_rdata_o = {7'd0, armed_q};
         `REG_SPEED:         reg_rdata_o = {6'd0, speed_q};
         `REG_PATTERN:       if (pat_lane_ok)
            reg_rdata_o = pattern_q[8*reg_bytecnt_i[PAT_IDX_W-1:0] +: 8];
         `REG_MASK:          if (pat_lane_ok)
            reg_rdata_o = mask_q[8*reg_bytecnt_i[PAT_IDX_W-1:0] +: 8];
         `REG_PATTERN_BYTES: reg_rdata_o = 8'(pattern_bytes_q);
         `REG_NUM_TRIGGERS:  reg_rdata_o = 8'(num_triggers_q);
         `REG_TRIG_DELAY:    if (lane_hit) reg_rdata_o = delay_bytes[8*lane_byte +: 8];
         `REG_TRIG_WIDTH:    if (lane_hit) reg_rdata_o = width_bytes[8*lane_byte +: 8];
         `REG_STATUS:        reg_rdata_o = {6'd0, triggered_q, armed_q};
         default: ;
      endcase
   end

   assign armed_o         = armed_q;
   assign speed_o         = speed_q;
   assign pattern_o       = pattern_q;
   assign mask_o          = mask_q;
   assign pattern_bytes_o = pattern_bytes_q;
   assign num_triggers_o  = num_triggers_q;
   assign trig_delay_o    = trig_delay_q;
   assign trig_width_o    = trig_width_q;

endmodule

/* hw/usb_pattern_matcher.sv */
`timescale 1ns/100ps
`include "usb_trigger_params.svh"

module usb_pattern_matcher import usb_trigger_pkg::*; (
   input  logic          fe_clk,
   input  logic          rst_i,
   input  logic          armed_i,
   input  pattern_t      pattern_i,
   input  pattern_t      mask_i,
   input  pattern_cnt_t  pattern_bytes_i,
   input  fe_byte_t      fe_data_i,
   input  logic          fe_rxvalid_i,
   output logic          match_o
);

   fe_byte_t      hist_q [`PATTERN_BYTES];   // byte 0 is newest
   pattern_cnt_t  hist_cnt_q;                // valid bytes, saturates
   logic          shifted_q;                 // last edge took a byte

   logic          bytes_equal;
   logic          enough_bytes;

   //////////////////////////////
   // received byte history
   //////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (rst_i || !armed_i) begin
         hist_cnt_q <= '0;
         shifted_q  <= 1'b0;
         for (int k = 0; k < `PATTERN_BYTES; k++) begin
            hist_q[k] <= '0;
         end
      end else begin
         shifted_q <= fe_rxvalid_i;
         if (fe_rxvalid_i) begin
            hist_q[0] <= fe_data_i;
            for (int k = 1; k < `PATTERN_BYTES; k++) begin
               hist_q[k] <= hist_q[k-1];
            end
            if (hist_cnt_q < pattern_cnt_t'(`PATTERN_BYTES))
               hist_cnt_q <= hist_cnt_q + 1'b1;
         end
      end
   end

   //////////////////////////////
   // masked compare
   //////////////////////////////

   // only bytes below the programmed length count
   always_comb begin
      bytes_equal = 1'b1;
      for (int k = 0; k < `PATTERN_BYTES; k++) begin
         if (pattern_cnt_t'(k) < pattern_bytes_i) begin
            if (((hist_q[k] ^ pattern_i[8*k +: 8]) & mask_i[8*k +: 8]) != 8'd0)
               bytes_equal = 1'b0;
         end
      end
   end

   // no match on a partly filled history
   assign enough_bytes = hist_cnt_q >= pattern_bytes_i;

   // one-cycle pulse after the completing byte
   always_ff @(posedge fe_clk) begin
      if (rst_i || !armed_i) begin
         match_o <= 1'b0;
      end else begin
         match_o <= shifted_q && enough_bytes && bytes_equal;
      end
   end

endmodule

/* hw/trigger_pulse_gen.sv */
`timescale 1ns/100ps
`include "usb_trigger_params.svh"

module trigger_pulse_gen import usb_trigger_pkg::*; (
   input  logic         fe_clk,
   input  logic         rst_i,
   input  logic         match_i,
   input  pulse_idx_t   num_triggers_i,
   input  trig_delay_t  trig_delay_i [`NUM_PULSES],
   input  trig_width_t  trig_width_i [`NUM_PULSES],
   output logic         trig_o,
   output logic         busy_o,
   output logic         done_o
);

   trig_state_t  state_q;
   pulse_idx_t   idx_q;
   trig_delay_t  cnt_q;        // shared by delay and width phases

   logic         cnt_last;
   logic         last_pulse;
   logic         load_pulse;
   pulse_idx_t   sel_idx;
   trig_delay_t  load_delay;
   trig_delay_t  load_width;
   trig_delay_t  cur_width;

   // width of 0 still gives one high cycle
   function automatic trig_delay_t eff_width(trig_width_t w);
      if (w == '0)
         return trig_delay_t'(1);
      else
         return trig_delay_t'(w);
   endfunction

   //////////////////////////////
   // next pulse selection
   //////////////////////////////
   assign cnt_last   = cnt_q == trig_delay_t'(1);
   assign last_pulse = idx_q == num_triggers_i;

   // first pulse from idle, next one when a pulse ends
   assign load_pulse = (state_q == TRIG_IDLE && match_i) ||
                       (state_q == TRIG_PULSE && cnt_last && !last_pulse);

   assign sel_idx    = (state_q == TRIG_IDLE) ? pulse_idx_t'(0) : idx_q + 1'b1;
   assign load_delay = trig_delay_i[sel_idx];
   assign load_width = eff_width(trig_width_i[sel_idx]);
   assign cur_width  = eff_width(trig_width_i[idx_q]);

   //////////////////////////////
   // pulse train FSM
   //////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         state_q <= TRIG_IDLE;
         idx_q   <= '0;
         cnt_q   <= '0;
         trig_o  <= 1'b0;
         done_o  <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state_q)
            TRIG_DELAY: begin
               if (cnt_last) begin
                  state_q <= TRIG_PULSE;
                  trig_o  <= 1'b1;
                  cnt_q   <= cur_width;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            TRIG_PULSE: begin
               if (cnt_last) begin
                  trig_o <= 1'b0;
                  if (last_pulse) begin
                     state_q <= TRIG_IDLE;
                     done_o  <= 1'b1;   // regs disarm on this
                  end
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            default: ;   // idle, matches handled below
         endcase

         // start of a pulse overrides the case above
         if (load_pulse) begin
            idx_q <= sel_idx;
            if (load_delay == '0) begin
               state_q <= TRIG_PULSE;   // no gap, go high now
               trig_o  <= 1'b1;
               cnt_q   <= load_width;
            end else begin
               state_q <= TRIG_DELAY;
               cnt_q   <= load_delay;
            end
         end
      end
   end

   assign busy_o = state_q != TRIG_IDLE;

endmodule

/* hw/usb_trigger_top.sv */
`timescale 1ns/100ps
`include "usb_trigger_params.svh"

module usb_trigger_top import usb_trigger_pkg::*; (
   input  logic        fe_clk,
   input  logic        rst_i,
   // register access
   input  reg_addr_t   reg_addr_i,
   input  bytecnt_t    reg_bytecnt_i,
   input  reg_data_t   reg_wdata_i,
   input  logic        reg_write_i,
   output reg_data_t   reg_rdata_o,
   // PHY receive side
   input  fe_byte_t    fe_data_i,
   input  logic        fe_rxvalid_i,
   output logic [1:0]  fe_xcvrsel_o,
   output logic        fe_termsel_o,
   // ChipWhisperer trigger and LEDs
   output logic        cw_trig_o,
   output logic        led_trig_o,
   output logic        led_cap_o
);

   logic          armed;
   logic          match;
   logic          trig_done;
   logic          trig_busy;
   usb_speed_t    speed;
   pattern_t      pattern;
   pattern_t      mask;
   pattern_cnt_t  pattern_bytes;
   pulse_idx_t    num_triggers;
   trig_delay_t   trig_delay [`NUM_PULSES];
   trig_width_t   trig_width [`NUM_PULSES];

   usb_trigger_regs u_regs (
      .fe_clk           (fe_clk),
      .rst_i            (rst_i),
      .reg_addr_i       (reg_addr_i),
      .reg_bytecnt_i    (reg_bytecnt_i),
      .reg_wdata_i      (reg_wdata_i),
      .reg_write_i      (reg_write_i),
      .reg_rdata_o      (reg_rdata_o),
      .trig_done_i      (trig_done),
      .armed_o          (armed),
      .speed_o          (speed),
      .pattern_o        (pattern),
      .mask_o           (mask),
      .pattern_bytes_o  (pattern_bytes),
      .num_triggers_o   (num_triggers),
      .trig_delay_o     (trig_delay),
      .trig_width_o     (trig_width)
   );

   usb_pattern_matcher u_matcher (
      .fe_clk           (fe_clk),
      .rst_i            (rst_i),
      .armed_i          (armed),
      .pattern_i        (pattern),
      .mask_i           (mask),
      .pattern_bytes_i  (pattern_bytes),
      .fe_data_i        (fe_data_i),
      .fe_rxvalid_i     (fe_rxvalid_i),
      .match_o          (match)
   );

   trigger_pulse_gen u_pulse_gen (
      .fe_clk           (fe_clk),
      .rst_i            (rst_i),
      .match_i          (match),
      .num_triggers_i   (num_triggers),
      .trig_delay_i     (trig_delay),
      .trig_width_i     (trig_width),
      .trig_o           (cw_trig_o),
      .busy_o           (trig_busy),
      .done_o           (trig_done)
   );

   //////////////////////////////
   // speed to PHY select decode
   //////////////////////////////
   always_comb begin
      case (speed)
         SPEED_LS: begin
            fe_xcvrsel_o = 2'b10;
            fe_termsel_o = 1'b1;
         end
         SPEED_HS: begin
            fe_xcvrsel_o = 2'b00;
            fe_termsel_o = 1'b0;   // HS termination
         end
         default: begin            // FS, and AUTO falls back to FS
            fe_xcvrsel_o = 2'b01;
            fe_termsel_o = 1'b1;
         end
      endcase
   end

   assign led_cap_o  = armed;
   assign led_trig_o = trig_busy;   // lit for the whole train

endmodule

/* sim/tb_usb_trigger.sv */
`timescale 1ns/100ps
`include "usb_trigger_params.svh"

module tb_usb_trigger import usb_trigger_pkg::*; ();

   logic        fe_clk;
   logic        rst_i;
   reg_addr_t   reg_addr_i;
   bytecnt_t    reg_bytecnt_i;
   reg_data_t   reg_wdata_i;
   logic        reg_write_i;
   reg_data_t   reg_rdata_o;
   fe_byte_t    fe_data_i;
   logic        fe_rxvalid_i;
   logic [1:0]  fe_xcvrsel_o;
   logic        fe_termsel_o;
   logic        cw_trig_o;
   logic        led_trig_o;
   logic        led_cap_o;

   int          seed = 32'h3728;
   fe_byte_t    pat  [`PATTERN_BYTES];   // expected pattern, mask and history
   fe_byte_t    msk  [`PATTERN_BYTES];
   fe_byte_t    hist [`PATTERN_BYTES];
   int          plen;
   int          hcnt;
   int          dly  [`NUM_PULSES];
   int          wid  [`NUM_PULSES];
   reg_data_t   lane_d [3*`NUM_PULSES];
   reg_data_t   lane_w [3*`NUM_PULSES];
   logic [63:0] mask_v;

   usb_trigger_top DUT (.*);

   initial begin
      fe_clk = 1'b0;
      forever #2 fe_clk = ~fe_clk;
   end

   //////////////////////////////
   // failure reporting
   //////////////////////////////
   task automatic abort_run(input string reason);
      $display("STATUS: FAIL");
      $display("%s", reason);
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      abort_run($sformatf("Error %s expected 0x%0h got 0x%0h", name, exp, got));
   endtask

   // a trigger pulse always belongs to a running train
   trig_needs_busy: assert property (@(posedge fe_clk) disable iff (rst_i)
                                     cw_trig_o |-> led_trig_o)
      else abort_run("cw_trig_o was high while the pulse generator was idle");

   //////////////////////////////
   // register access
   //////////////////////////////
   task automatic write_reg(input reg_addr_t addr, input int lane, input int data);
      @(negedge fe_clk);
      reg_addr_i    = addr;
      reg_bytecnt_i = bytecnt_t'(lane);
      reg_wdata_i   = reg_data_t'(data);
      reg_write_i   = 1'b1;
      @(negedge fe_clk);
      reg_write_i   = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, input int lane, output reg_data_t data);
      @(negedge fe_clk);
      reg_addr_i    = addr;
      reg_bytecnt_i = bytecnt_t'(lane);
      #1 data = reg_rdata_o;   // read mux is combinational
   endtask

   task automatic check_reg(input reg_addr_t addr, input int lane, input int exp);
      reg_data_t got;
      read_reg(addr, lane, got);
      assert (got == reg_data_t'(exp))
         else report_mismatch($sformatf("reg_rdata_o[%0h/%0d]", addr, lane), exp, got);
   endtask

   task automatic set_pulse(input int p, input int d, input int w);
      dly[p] = d;
      wid[p] = w;
      for (int b = 0; b < 3; b++) begin
         write_reg(`REG_TRIG_DELAY, 3*p + b, (d >> (8*b)) & 8'hff);
         write_reg(`REG_TRIG_WIDTH, 3*p + b, (w >> (8*b)) & 8'hff);
      end
   endtask

   task automatic load_pattern(input int len, input logic [63:0] mask_bits);
      for (int k = 0; k < `PATTERN_BYTES; k++) begin
         pat[k] = $random(seed);
         msk[k] = mask_bits[8*k +: 8];
         write_reg(`REG_PATTERN, k, pat[k]);
         write_reg(`REG_MASK, k, msk[k]);
      end
      plen = len;
      write_reg(`REG_PATTERN_BYTES, 0, len);
   endtask

   task automatic arm_trigger;
      write_reg(`REG_ARM, 0, 1);
      hcnt = 0;   // history starts empty after arming
      for (int k = 0; k < `PATTERN_BYTES; k++) hist[k] = '0;
      assert (led_cap_o) else abort_run("led_cap_o stayed low after an arm write");
   endtask

   //////////////////////////////
   // receive side stimulus
   //////////////////////////////

   // would this byte finish the pattern under the mask
   function automatic logic completes(input fe_byte_t b);
      logic     hit;
      fe_byte_t h;
      hit = (hcnt + 1 >= plen);
      for (int k = 0; k < plen; k++) begin
         h = (k == 0) ? b : hist[k-1];
         if (((h ^ pat[k]) & msk[k]) != 8'd0) hit = 1'b0;
      end
      return hit;
   endfunction

   task automatic send_byte(input fe_byte_t b);
      @(negedge fe_clk);
      fe_data_i    = b;
      fe_rxvalid_i = 1'b1;
      for (int k = `PATTERN_BYTES-1; k > 0; k--) hist[k] = hist[k-1];
      hist[0] = b;
      if (hcnt < `PATTERN_BYTES) hcnt++;
   endtask

   task automatic end_burst;
      @(negedge fe_clk);
      fe_rxvalid_i = 1'b0;
   endtask

   task automatic send_filler(input int n);
      fe_byte_t b;
      repeat (n) begin
         b = $random(seed);
         while (completes(b)) b = $random(seed);   // re-draw
         send_byte(b);
      end
   endtask

   // oldest pattern byte goes first and flip toggles bits on the way
   task automatic send_pattern(input logic [63:0] flip);
      for (int k = plen-1; k >= 0; k--) send_byte(pat[k] ^ flip[8*k +: 8]);
      end_burst();
   endtask

   //////////////////////////////
   // trigger observation
   //////////////////////////////
   task automatic wait_rise(input int limit, input int busy_from, output int cycles);
      cycles = 0;
      while (!cw_trig_o) begin
         if (cycles >= busy_from)
            assert (led_trig_o) else abort_run("led_trig_o was low inside a pulse train");
         if (cycles >= limit) abort_run("timeout waiting for cw_trig_o to rise");
         @(negedge fe_clk);
         cycles++;
      end
   endtask

   task automatic wait_fall(input int limit, output int cycles);
      cycles = 0;
      while (cw_trig_o) begin
         if (cycles >= limit) abort_run("timeout waiting for cw_trig_o to fall");
         @(negedge fe_clk);
         cycles++;
      end
   endtask

   task automatic check_pulse(input int p, input int exp_low, input int busy_from);
      int low;
      int high;
      int exp_high;
      exp_high = (wid[p] == 0) ? 1 : wid[p];   // zero width still gives one cycle
      wait_rise(exp_low + 20, busy_from, low);
      assert (low == exp_low)
         else report_mismatch($sformatf("cw_trig_o low cycles, pulse %0d", p), exp_low, low);
      wait_fall(exp_high + 20, high);
      assert (high == exp_high)
         else report_mismatch($sformatf("cw_trig_o high cycles, pulse %0d", p), exp_high, high);
   endtask

   task automatic expect_quiet(input int n);
      repeat (n) begin
         @(negedge fe_clk);
         assert (!cw_trig_o) else abort_run("cw_trig_o rose without a valid armed match");
      end
   endtask

   task automatic wait_disarm(input int limit);
      int cycles;
      cycles = 0;
      while (led_cap_o) begin
         if (cycles >= limit) abort_run("timeout waiting for armed to clear after the train");
         @(negedge fe_clk);
         cycles++;
      end
   endtask

   function automatic logic [2:0] phy_select(input int s);
      case (s)
         1:       return 3'b101;   // LS
         2:       return 3'b000;   // HS
         default: return 3'b011;   // FS and AUTO
      endcase
   endfunction

   //////////////////////////////
   // test sequence
   //////////////////////////////
   initial begin
      rst_i         = 1'b1;
      reg_addr_i    = '0;
      reg_bytecnt_i = '0;
      reg_wdata_i   = '0;
      reg_write_i   = 1'b0;
      fe_data_i     = '0;
      fe_rxvalid_i  = 1'b0;
      plen          = 1;
      hcnt          = 0;
      repeat (5) @(posedge fe_clk);
      @(negedge fe_clk) rst_i = 1'b0;

      // reset defaults
      assert ({cw_trig_o, led_trig_o, led_cap_o} == 3'b000)
         else report_mismatch("{cw_trig_o,led_trig_o,led_cap_o}", 0,
                              {cw_trig_o, led_trig_o, led_cap_o});
      assert ({fe_xcvrsel_o, fe_termsel_o} == phy_select(0))
         else report_mismatch("{fe_xcvrsel_o,fe_termsel_o}", phy_select(0),
                              {fe_xcvrsel_o, fe_termsel_o});
      check_reg(`REG_ARM, 0, 0);
      check_reg(`REG_SPEED, 0, 0);
      for (int k = 0; k < `PATTERN_BYTES; k++) begin
         check_reg(`REG_PATTERN, k, 0);
         check_reg(`REG_MASK, k, 0);
      end
      check_reg(`REG_PATTERN_BYTES, 0, 1);
      check_reg(`REG_NUM_TRIGGERS, 0, 0);
      for (int l = 0; l < 3*`NUM_PULSES; l++) begin
         check_reg(`REG_TRIG_DELAY, l, 0);
         check_reg(`REG_TRIG_WIDTH, l, (l % 3 == 0) ? 1 : 0);
      end
      check_reg(`REG_STATUS, 0, 0);

      // readback of every lane
      load_pattern(1, {$random(seed), $random(seed)});
      for (int l = 0; l < 3*`NUM_PULSES; l++) begin
         lane_d[l] = $random(seed);
         lane_w[l] = $random(seed);
         write_reg(`REG_TRIG_DELAY, l, lane_d[l]);
         write_reg(`REG_TRIG_WIDTH, l, lane_w[l]);
      end
      for (int k = 0; k < `PATTERN_BYTES; k++) begin
         check_reg(`REG_PATTERN, k, pat[k]);
         check_reg(`REG_MASK, k, msk[k]);
      end
      for (int l = 0; l < 3*`NUM_PULSES; l++) begin
         check_reg(`REG_TRIG_DELAY, l, (l % 3 == 2) ? lane_d[l] & 8'h0f : lane_d[l]);
         check_reg(`REG_TRIG_WIDTH, l, (l % 3 == 2) ? lane_w[l] & 8'h01 : lane_w[l]);
      end
      write_reg(`REG_PATTERN_BYTES, 0, 0);
      check_reg(`REG_PATTERN_BYTES, 0, 1);
      write_reg(`REG_PATTERN_BYTES, 0, 12);
      check_reg(`REG_PATTERN_BYTES, 0, 8);

      // speed decode
      for (int s = 0; s < 4; s++) begin
         write_reg(`REG_SPEED, 0, s);
         assert ({fe_xcvrsel_o, fe_termsel_o} == phy_select(s))
            else report_mismatch("{fe_xcvrsel_o,fe_termsel_o}", phy_select(s),
                                 {fe_xcvrsel_o, fe_termsel_o});
      end
      write_reg(`REG_SPEED, 0, 0);

      // single pulse
      // the generator leaves idle two edges after the completing byte
      load_pattern(3, '1);
      write_reg(`REG_NUM_TRIGGERS, 0, 0);
      set_pulse(0, $random(seed) & 31, 1 + ($random(seed) & 15));
      arm_trigger();
      send_filler(5);
      send_pattern('0);
      check_pulse(0, 2 + dly[0], 2);
      wait_disarm(8);
      check_reg(`REG_STATUS, 0, 2);   // triggered and no longer armed

      // masked-off bits are ignored but compared bits are not
      for (int k = 0; k < `PATTERN_BYTES; k++)
         mask_v[8*k +: 8] = ($random(seed) | 8'h01) & 8'hef;
      load_pattern(3, mask_v);
      arm_trigger();
      send_filler(5);
      send_pattern(64'h0000_0000_0010_1010);
      check_pulse(0, 2 + dly[0], 2);
      wait_disarm(8);
      arm_trigger();
      send_filler(5);
      send_pattern(64'h0000_0000_0000_0100);
      expect_quiet(60);
      write_reg(`REG_ARM, 0, 0);
      assert (!led_cap_o) else abort_run("led_cap_o stayed high after a disarm write");
      send_filler(5);
      send_pattern('0);
      expect_quiet(60);

      // four pulse train with a second pattern landing mid-train
      load_pattern(3, '1);
      write_reg(`REG_NUM_TRIGGERS, 0, 3);
      for (int p = 0; p < `NUM_PULSES; p++)
         set_pulse(p, (p == 0) ? $random(seed) & 7 : 2 + ($random(seed) & 7),
                   (p == 2) ? 0 : $random(seed) & 7);
      arm_trigger();
      send_filler(5);
      send_pattern('0);
      fork
         begin
            repeat (3) @(negedge fe_clk);
            send_pattern('0);
         end
      join_none
      check_pulse(0, 2 + dly[0], 2);
      for (int p = 1; p < `NUM_PULSES; p++) check_pulse(p, dly[p], 0);
      assert (!led_trig_o) else abort_run("led_trig_o still high after the last pulse");
      expect_quiet(80);
      assert (!led_cap_o) else abort_run("led_cap_o still high after the train");

      $display("STATUS: PASS");
      $finish;
   end

endmodule

/* usb_trigger.f */
+incdir+include
hw/usb_trigger_pkg.sv
hw/usb_trigger_regs.sv
hw/usb_pattern_matcher.sv
hw/trigger_pulse_gen.sv
hw/usb_trigger_top.sv
sim/tb_usb_trigger.sv

/* Bender.yml */
package:
  name: usb_trigger

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/usb_trigger_pkg.sv
      - hw/usb_trigger_regs.sv
      - hw/usb_pattern_matcher.sv
      - hw/trigger_pulse_gen.sv
      - hw/usb_trigger_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_usb_trigger.sv
